// ==== verilog/calc_pkg.sv ====
// Calculator package: sizes, key codes, FSM states, memory write port and APB structs
package calc_pkg;

    localparam int data_width     = 16;               // Operand and result width
    localparam int bcd_digits     = 5;                // Display digit count
    localparam int bcd_width      = 4 * bcd_digits;   // Packed BCD width
    localparam int mem_words      = 3;                // Stored words
    localparam int apb_addr_width = 4;                // Byte address bits

    // Keypad opcodes, 14 and 15 are left unencoded
    typedef enum logic [3:0] {
        key_0     = 4'd0,
        key_1     = 4'd1,
        key_2     = 4'd2,
        key_3     = 4'd3,
        key_4     = 4'd4,
        key_5     = 4'd5,
        key_6     = 4'd6,
        key_7     = 4'd7,
        key_8     = 4'd8,
        key_9     = 4'd9,
        key_plus  = 4'd10,
        key_minus = 4'd11,
        key_equal = 4'd12,
        key_clear = 4'd13
    } key_code_t;

    typedef struct packed {
        logic      valid;                             // One-cycle strobe
        key_code_t code;
    } key_event_t;

    typedef enum logic [2:0] {
        st_first,                                     // Entering operand 1
        st_second,                                    // Entering operand 2
        st_calc,                                      // Add or subtract
        st_convert,                                   // Waiting on BCD converter
        st_show                                       // Result on display
    } calc_state_t;

    typedef enum logic [1:0] {
        word_operand1 = 2'd0,
        word_operand2 = 2'd1,
        word_result   = 2'd2
    } mem_addr_t;

    typedef struct packed {
        logic                  en;
        mem_addr_t             addr;
        logic [data_width-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [apb_addr_width-1:0] paddr;             // Byte address
        logic [data_width-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_width-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

// ==== verilog/bin_to_bcd.sv ====
// Sequential double dabble converter from 16-bit binary to five BCD digits
`timescale 1ns/1ps

module bin_to_bcd (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,   // Load value
    input  logic [calc_pkg::data_width-1:0] value,   // Binary input
    output logic                            done,    // One-cycle pulse
    output logic [calc_pkg::bcd_width-1:0]  bcd      // Stable after done
);
    import calc_pkg::*;

    localparam int sr_width  = bcd_width + data_width;
    localparam int cnt_width = $clog2(data_width);

    logic [sr_width-1:0]  shift_reg;                 // {bcd, binary}
    logic [sr_width-1:0]  shift_next;
    logic [cnt_width-1:0] step_cnt;
    logic                 active;

    // Add 3 to each digit >= 5 and then shift left one
    function automatic logic [sr_width-1:0] dabble_step(input logic [sr_width-1:0] sr);
        logic [bcd_width-1:0] digits;
        digits = sr[sr_width-1 -: bcd_width];
        for (int i = 0; i < bcd_digits; i++) begin
            if (digits[4*i +: 4] >= 4'd5) begin
                digits[4*i +: 4] = digits[4*i +: 4] + 4'd3;
            end
        end
        return {digits, sr[data_width-1:0]} << 1;
    endfunction

    assign shift_next = dabble_step(shift_reg);

    // Step control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active   <= 1'b1;
                step_cnt <= '0;
            end else if (active) begin
                step_cnt <= step_cnt + cnt_width'(1);
                if (step_cnt == cnt_width'(data_width - 1)) begin
                    active <= 1'b0;                  // Last shift
                    done   <= 1'b1;                  // Finish cycle
                end
            end
        end
    end

    // Shift register and result
    always_ff @(posedge clk) begin
        if (start) begin
            shift_reg <= {{bcd_width{1'b0}}, value};
        end else if (active) begin
            shift_reg <= shift_next;
            if (step_cnt == cnt_width'(data_width - 1)) begin
                bcd <= shift_next[sr_width-1 -: bcd_width];  // Held until next run
            end
        end
    end

endmodule

// ==== verilog/operand_memory.sv ====
// Operand memory: three words, controller write port and read-only APB slave
`timescale 1ns/1ps

module operand_memory (
    input  logic               clk,
    input  logic               reset,
    input  calc_pkg::mem_wr_t  mem_wr,     // From controller
    input  calc_pkg::apb_req_t apb_req,    // Host request
    output calc_pkg::apb_rsp_t apb_rsp     // Zero wait state response
);
    import calc_pkg::*;

    logic [data_width-1:0] words [mem_words];
    logic                  access;                  // APB access phase
    logic [1:0]            word_idx;                // Byte address to word
    logic                  addr_hit;
    logic                  wr_hit;

    assign access   = apb_req.psel && apb_req.penable;
    assign word_idx = apb_req.paddr[3:2];

    // Word aligned and inside the three words
    assign addr_hit = (apb_req.paddr[1:0] == 2'b00) && (int'(word_idx) < mem_words);

    assign wr_hit = mem_wr.en && (int'(mem_wr.addr) < mem_words);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                words[i] <= '0;                     // Reads return zero after reset
            end
        end else if (wr_hit) begin
            words[mem_wr.addr] <= mem_wr.data;
        end
    end

    // Same-cycle read data, so pready follows the access phase
    always_comb begin
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access && (apb_req.pwrite || !addr_hit);  // Host writes refused
        apb_rsp.prdata  = '0;
        if (access && !apb_req.pwrite && addr_hit) begin
            apb_rsp.prdata = words[word_idx];
        end
    end

endmodule

// ==== verilog/calc_controller.sv ====
// Calculator controller: key entry FSM, operand build, add/sub, memory writes, display latch
`timescale 1ns/1ps

module calc_controller (
    input  logic                             clk,
    input  logic                             reset,
    input  calc_pkg::key_event_t             key,          // Keypad strobe
    input  logic                             conv_done,    // Converter finished
    input  logic [calc_pkg::bcd_width-1:0]   conv_bcd,     // Converted digits
    output calc_pkg::mem_wr_t                mem_wr,       // Operand memory write port
    output logic                             conv_start,   // One-cycle converter kick
    output logic [calc_pkg::data_width-1:0]  conv_value,   // Value to convert
    output logic                             busy,         // Keys dropped while high
    output logic                             complete,     // High for the st_show cycle
    output logic [calc_pkg::bcd_width-1:0]   display_bcd   // Held until next complete
);
    import calc_pkg::*;

    calc_state_t           state;
    calc_state_t           state_next;
    key_code_t             op_key;                         // Plus or minus
    logic [data_width-1:0] operand1;
    logic [data_width-1:0] operand2;
    logic [data_width-1:0] result;
    logic [data_width-1:0] entry_value;                    // Operand being typed
    logic [data_width-1:0] entry_next;                     // Value times ten plus digit
    logic [data_width-1:0] digit_value;
    logic [data_width-1:0] calc_value;
    logic                  key_ok;
    logic                  key_digit;
    logic                  wr_en;
    mem_addr_t             wr_addr;
    logic [data_width-1:0] wr_data;

    assign busy     = (state == st_calc) || (state == st_convert) || (state == st_show);
    assign complete = (state == st_show);
    assign key_ok   = key.valid && !busy;                  // Only acceptance point for keys
    assign key_digit = key_ok && (key.code <= key_9);

    // Decimal shift, x*10 = x*8 + x*2, wraps at 16 bits
    assign entry_value = (state == st_second) ? operand2 : operand1;
    assign digit_value = data_width'(key.code);
    assign entry_next  = (entry_value << 3) + (entry_value << 1) + digit_value;

    assign calc_value = (op_key == key_minus) ? (operand1 - operand2)
                                              : (operand1 + operand2);

    assign mem_wr     = '{en: wr_en, addr: wr_addr, data: wr_data};
    assign conv_value = result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_first;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_first: begin
                if (key_ok && (key.code == key_plus || key.code == key_minus)) begin
                    state_next = st_second;                // Operator picked
                end
            end
            st_second: begin
                if (key_ok && key.code == key_clear) begin
                    state_next = st_first;
                end else if (key_ok && key.code == key_equal) begin
                    state_next = st_calc;
                end
            end
            st_calc:    state_next = st_convert;           // Single compute cycle
            st_convert: begin
                if (conv_done) begin
                    state_next = st_show;
                end
            end
            st_show:    state_next = st_first;
            default:    state_next = st_first;
        endcase
    end

    // Operands, operation, strobes and display
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            operand1    <= '0;
            operand2    <= '0;
            op_key      <= key_plus;
            wr_en       <= 1'b0;
            conv_start  <= 1'b0;
            display_bcd <= '0;
        end else begin
            wr_en      <= 1'b0;                            // Pulses by default
            conv_start <= 1'b0;
            case (state)
                st_first, st_second: begin
                    if (key_digit) begin
                        if (state == st_first) begin
                            operand1 <= entry_next;
                        end else begin
                            operand2 <= entry_next;
                        end
                        wr_en <= 1'b1;                     // Store lands one cycle later
                    end else if (key_ok && key.code == key_clear) begin
                        operand1 <= '0;                    // Memory keeps old words
                        operand2 <= '0;
                        op_key   <= key_plus;
                    end else if (key_ok && state == st_first &&
                                 (key.code == key_plus || key.code == key_minus)) begin
                        op_key <= key.code;
                    end
                end
                st_calc: begin
                    wr_en      <= 1'b1;                    // Result word
                    conv_start <= 1'b1;                    // First st_convert cycle
                end
                st_convert: begin
                    if (conv_done) begin
                        display_bcd <= conv_bcd;           // Visible with complete
                    end
                end
                st_show: begin
                    operand1 <= '0;
                    operand2 <= '0;
                    op_key   <= key_plus;
                end
                default: begin
                    operand1 <= '0;
                    operand2 <= '0;
                end
            endcase
        end
    end

    // Write payload and result
    always_ff @(posedge clk) begin
        if (state == st_calc) begin
            result  <= calc_value;
            wr_addr <= word_result;
            wr_data <= calc_value;
        end else if (key_digit) begin
            wr_addr <= (state == st_second) ? word_operand2 : word_operand1;
            wr_data <= entry_next;
        end
    end

endmodule

// ==== verilog/calc_top.sv ====
// Calculator top level: controller, operand memory and BCD converter
`timescale 1ns/1ps

module calc_top (
    input  logic                            clk,
    input  logic                            reset,
    input  calc_pkg::key_event_t            key,          // Keypad strobes
    input  calc_pkg::apb_req_t              apb_req,      // Host read port
    output calc_pkg::apb_rsp_t              apb_rsp,
    output logic                            busy,         // Keys dropped
    output logic                            complete,     // Result ready pulse
    output logic [calc_pkg::bcd_width-1:0]  display_bcd   // Five BCD digits
);
    import calc_pkg::*;

    mem_wr_t               mem_wr;                         // Controller to memory
    logic                  conv_start;
    logic [data_width-1:0] conv_value;
    logic                  conv_done;
    logic [bcd_width-1:0]  conv_bcd;

    calc_controller controller_i (
        .clk         (clk),
        .reset       (reset),
        .key         (key),
        .conv_done   (conv_done),
        .conv_bcd    (conv_bcd),
        .mem_wr      (mem_wr),
        .conv_start  (conv_start),
        .conv_value  (conv_value),
        .busy        (busy),
        .complete    (complete),
        .display_bcd (display_bcd)
    );

    // Words readable by the host
    operand_memory memory_i (
        .clk     (clk),
        .reset   (reset),
        .mem_wr  (mem_wr),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // 17 cycles start to done
    bin_to_bcd converter_i (
        .clk   (clk),
        .reset (reset),
        .start (conv_start),
        .value (conv_value),
        .done  (conv_done),
        .bcd   (conv_bcd)
    );

endmodule

// ==== verif/calc_properties.sv ====
// Bound assertions on calc_top ports: complete pulse, APB ready, display hold, busy in reset
`timescale 1ns/1ps

module calc_properties (
    input logic                           clk,
    input logic                           reset,
    input calc_pkg::apb_req_t             apb_req,
    input calc_pkg::apb_rsp_t             apb_rsp,
    input logic                           busy,
    input logic                           complete,
    input logic [calc_pkg::bcd_width-1:0] display_bcd
);
    int pulse_fails   = 0;
    int ready_fails   = 0;
    int display_fails = 0;
    int reset_fails   = 0;
    int fail_total;                                        // Read by the testbench at the end

    assign fail_total = pulse_fails + ready_fails + display_fails + reset_fails;

    complete_pulse: assert property (@(posedge clk) disable iff (reset) complete |=> !complete)
        else begin
            $error("complete high on two cycles in a row");
            pulse_fails++;
        end

    // Zero wait states
    ready_in_access: assert property (@(posedge clk) disable iff (reset)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else begin
            $error("pready low in an APB access phase");
            ready_fails++;
        end

    display_hold: assert property (@(posedge clk) disable iff (reset)
        !$stable(display_bcd) |-> complete)
        else begin
            $error("display_bcd changed outside a complete cycle");
            display_fails++;
        end

    idle_in_reset: assert property (@(posedge clk) reset |-> !busy)
        else begin
            $error("busy high during reset");
            reset_fails++;
        end

endmodule

bind calc_top calc_properties props_i (
    .clk         (clk),
    .reset       (reset),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .busy        (busy),
    .complete    (complete),
    .display_bcd (display_bcd)
);

// ==== verif/calc_tb.sv ====
// Calculator testbench with stimulus table, key driver, APB reader, model, checks and watchdog
`timescale 1ns/1ps

module calc_tb;
    import calc_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int num_cases    = 8;
    localparam int latency      = 20;                      // Equal key to complete

    // One row per calculation
    string     a_tab     [num_cases] = '{"12", "500", "999999", "65535",
                                         "123", "88", "654321", "7"};
    key_code_t op_tab    [num_cases] = '{key_plus, key_minus, key_plus, key_plus,
                                         key_plus, key_minus, key_minus, key_minus};
    string     b_tab     [num_cases] = '{"34", "1200", "7", "1",
                                         "45", "8", "123456", "40"};
    bit        busy_tab  [num_cases] = '{0, 0, 0, 0, 1, 0, 1, 0};   // Keys while busy
    bit        clear_tab [num_cases] = '{0, 0, 0, 0, 0, 1, 1, 0};   // Junk entry then clear

    logic                 clk = 1'b0;
    logic                 reset;
    key_event_t           key;
    apb_req_t             apb_req;
    apb_rsp_t             apb_rsp;
    logic                 busy;
    logic                 complete;
    logic [bcd_width-1:0] display_bcd;

    calc_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .key         (key),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .busy        (busy),
        .complete    (complete),
        .display_bcd (display_bcd)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic end_with_failure;
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        end_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // Operand built digit by digit as times ten plus digit modulo 65536
    function automatic logic [15:0] build_operand(input string s);
        int v;
        v = 0;
        for (int i = 0; i < s.len(); i++) begin
            v = (v * 10 + (int'(s[i]) - 48)) % 65536;
        end
        return 16'(v);
    endfunction

    function automatic logic [15:0] calc_result(input logic [15:0] a, input logic [15:0] b,
                                                input key_code_t op);
        if (op == key_minus) begin
            return a - b;                                  // Wraps in 16 bits
        end
        return a + b;
    endfunction

    function automatic logic [bcd_width-1:0] to_bcd(input logic [15:0] v);
        int                   n;
        logic [bcd_width-1:0] r;
        n = int'(v);
        r = '0;
        for (int i = 0; i < bcd_digits; i++) begin
            r[4*i +: 4] = 4'(n % 10);                      // Lowest digit first
            n = n / 10;
        end
        return r;
    endfunction

    task automatic send_key(input key_code_t code);
        @(posedge clk);
        #2;
        key.valid = 1'b1;
        key.code  = code;
        @(posedge clk);
        #2;
        key.valid = 1'b0;                                  // Idle cycle follows
    endtask

    task automatic enter_digits(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_key(key_code_t'(4'(s[i] - 8'd48)));
        end
    endtask

    // Counts edges from the edge that drove equal and may throw keys at the busy DUT
    task automatic wait_complete(input bit busy_keys);
        int cycles;
        cycles = 1;
        while (!complete) begin
            @(posedge clk);
            #2;
            cycles++;
            key.valid = 1'b0;
            if (busy_keys && (cycles == 3 || cycles == 5 || cycles == 9)) begin
                check_value("busy", 32'(busy), 32'd1);
                key.valid = 1'b1;
                key.code  = (cycles == 9) ? key_equal : key_9;   // Must be dropped
            end
            assert (complete || cycles < latency) else
                abort_run("no complete within 20 cycles of the equal key");
        end
        check_value("complete latency", 32'(cycles), 32'(latency));
        check_value("busy", 32'(busy), 32'd1);             // Still busy in st_show
    endtask

    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata,
                                output logic slverr);
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b1;                            // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;                            // Access phase
        @(negedge clk);
        check_value("pready", 32'(apb_rsp.pready), 32'd1);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic apb_read_check(input logic [3:0] addr, input logic [15:0] exp,
                                  input string name);
        logic [15:0] rdata;
        logic        slverr;
        apb_transfer(1'b0, addr, 16'h0000, rdata, slverr);
        check_value("pslverr", 32'(slverr), 32'd0);
        check_value(name, 32'(rdata), 32'(exp));
    endtask

    initial begin
        #((num_cases * 200 + reset_cycles) * clk_period);
        $display("Timeout at %0t ns: the test sequence did not finish", $time);
        end_with_failure();
    end

    initial begin
        logic [15:0] exp_a;
        logic [15:0] exp_b;
        logic [15:0] exp_r;
        logic [15:0] rdata;
        logic        slverr;
        reset   = 1'b1;
        key     = '0;
        apb_req = '0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;

        // Quiet outputs and empty memory after reset
        @(negedge clk);
        check_value("complete", 32'(complete), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("display_bcd", 32'(display_bcd), 32'd0);
        apb_read_check(4'd0, 16'h0000, "word_operand1");
        apb_read_check(4'd4, 16'h0000, "word_operand2");
        apb_read_check(4'd8, 16'h0000, "word_result");

        exp_a = '0;
        for (int row = 0; row < num_cases; row++) begin
            if (clear_tab[row]) begin
                enter_digits("777");
                send_key(key_minus);
                enter_digits("31");
                send_key(key_clear);                       // Back to st_first
            end
            enter_digits(a_tab[row]);
            send_key(op_tab[row]);
            enter_digits(b_tab[row]);
            send_key(key_equal);
            wait_complete(busy_tab[row]);

            exp_a = build_operand(a_tab[row]);
            exp_b = build_operand(b_tab[row]);
            exp_r = calc_result(exp_a, exp_b, op_tab[row]);
            check_value("display_bcd", 32'(display_bcd), 32'(to_bcd(exp_r)));
            apb_read_check(4'd0, exp_a, "word_operand1");
            apb_read_check(4'd4, exp_b, "word_operand2");
            apb_read_check(4'd8, exp_r, "word_result");
        end

        // Host write and unmapped read are refused
        apb_transfer(1'b1, 4'd0, 16'hbeef, rdata, slverr);
        check_value("pslverr on write", 32'(slverr), 32'd1);
        check_value("prdata on write", 32'(rdata), 32'd0);
        apb_transfer(1'b0, 4'd12, 16'h0000, rdata, slverr);
        check_value("pslverr on address 12", 32'(slverr), 32'd1);
        check_value("prdata on address 12", 32'(rdata), 32'd0);
        apb_read_check(4'd0, exp_a, "word_operand1");

        if (dut_i.props_i.fail_total == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Bound port assertions failed %0d times", dut_i.props_i.fail_total);
            end_with_failure();
        end
    end

endmodule

// ==== calc.f ====
verilog/calc_pkg.sv
verilog/bin_to_bcd.sv
verilog/operand_memory.sv
verilog/calc_controller.sv
verilog/calc_top.sv
verif/calc_properties.sv
verif/calc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the calculator testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module calc_tb -Mdir obj_dir -f calc.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vcalc_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "sim passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
